/* cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// first fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

// data and address width
`define CPU_XLEN 32

// architectural register count, register 0 included
`define CPU_NREGS 32

`endif

/* cpu_pkg.sv */
`include "cpu_config.svh"

package cpu_pkg;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_t;

    typedef enum logic [2:0] {ADD, SUB, AND, OR, SLT, LUI} alu_op_t;

    // operand source: register file, memory stage or writeback stage
    typedef enum logic [1:0] {REG, MEM, WB} fwd_sel_t;

    typedef struct packed {
        logic    regwrite;
        logic    memread;
        logic    memwrite;
        logic    alu_src_imm;
        alu_op_t alu_op;
    } ctrl_t;

    typedef struct packed {
        logic [31:0]          instr;
        logic [`CPU_XLEN-1:0] pc;
    } fd_t;

    typedef struct packed {
        ctrl_t                ctrl;
        logic [`CPU_XLEN-1:0] pc;
        logic [`CPU_XLEN-1:0] rsdata;
        logic [`CPU_XLEN-1:0] rtdata;
        logic [`CPU_XLEN-1:0] imm;
        logic [4:0]           rs;
        logic [4:0]           rt;
        logic [4:0]           wnum;
    } de_t;

    typedef struct packed {
        ctrl_t                ctrl;
        logic [`CPU_XLEN-1:0] pc;
        logic [`CPU_XLEN-1:0] alu_out;
        logic [`CPU_XLEN-1:0] rtdata;
        logic [4:0]           wnum;
    } em_t;

    typedef struct packed {
        logic                 regwrite;
        logic                 memread;
        logic [`CPU_XLEN-1:0] pc;
        logic [`CPU_XLEN-1:0] alu_out;
        logic [`CPU_XLEN-1:0] rdata;
        logic [4:0]           wnum;
    } mw_t;

    // operand select shared by the decode and execute forward paths
    function automatic logic [`CPU_XLEN-1:0] fwd_mux(
        input fwd_sel_t             sel,
        input logic [`CPU_XLEN-1:0] reg_val,
        input logic [`CPU_XLEN-1:0] mem_val,
        input logic [`CPU_XLEN-1:0] wb_val
    );
        case (sel)
            MEM:     return mem_val;
            WB:      return wb_val;
            default: return reg_val;
        endcase
    endfunction

endpackage

/* hazard_if.sv */
`timescale 1ns/1ps

interface hazard_if;

    // stage state reported by the datapath
    logic [4:0]        d_rs;
    logic [4:0]        d_rt;
    logic              d_is_branch;
    logic [4:0]        e_rs;
    logic [4:0]        e_rt;
    logic [4:0]        e_wnum;
    logic              e_regwrite;
    logic              e_memread;
    logic [4:0]        m_wnum;
    logic              m_regwrite;
    logic              m_memread;
    logic [4:0]        w_wnum;
    logic              w_regwrite;

    // decisions back to the datapath
    cpu_pkg::fwd_sel_t d_fwd_a;
    cpu_pkg::fwd_sel_t d_fwd_b;
    cpu_pkg::fwd_sel_t e_fwd_a;
    cpu_pkg::fwd_sel_t e_fwd_b;
    logic              stall_f;
    logic              stall_d;
    logic              flush_e;

    modport dp (
        output d_rs, d_rt, d_is_branch, e_rs, e_rt, e_wnum, e_regwrite, e_memread,
               m_wnum, m_regwrite, m_memread, w_wnum, w_regwrite,
        input  d_fwd_a, d_fwd_b, e_fwd_a, e_fwd_b, stall_f, stall_d, flush_e
    );

    modport hz (
        input  d_rs, d_rt, d_is_branch, e_rs, e_rt, e_wnum, e_regwrite, e_memread,
               m_wnum, m_regwrite, m_memread, w_wnum, w_regwrite,
        output d_fwd_a, d_fwd_b, e_fwd_a, e_fwd_b, stall_f, stall_d, flush_e
    );

endinterface

/* pipe_reg.sv */
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     stall,
    input  logic     clear,
    input  payload_t d,
    output payload_t q
);

    // a cleared payload decodes as a bubble downstream
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

/* regfile.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module regfile (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wen,
    input  logic [4:0]           waddr,
    input  logic [`CPU_XLEN-1:0] wdata,
    input  logic [4:0]           raddr_a,
    input  logic [4:0]           raddr_b,
    output logic [`CPU_XLEN-1:0] rdata_a,
    output logic [`CPU_XLEN-1:0] rdata_b
);

    // register 0 has no storage
    logic [`CPU_XLEN-1:0] regs [1:`CPU_NREGS-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // writeback data bypasses the array in the same cycle
    assign rdata_a = (raddr_a == 5'd0)                ? '0    :
                     (wen && waddr == raddr_a)        ? wdata :
                                                        regs[raddr_a];
    assign rdata_b = (raddr_b == 5'd0)                ? '0    :
                     (wen && waddr == raddr_b)        ? wdata :
                                                        regs[raddr_b];

endmodule

/* hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
    hazard_if.hz hz
);

    logic load_use;
    logic branch_stall;
    logic stall;

    // newest producer wins, register 0 never forwards
    function automatic cpu_pkg::fwd_sel_t pick_src(
        input logic [4:0] src,
        input logic       m_we,
        input logic [4:0] m_wnum,
        input logic       w_we,
        input logic [4:0] w_wnum
    );
        if (src == 5'd0) begin
            return cpu_pkg::REG;
        end
        if (m_we && m_wnum == src) begin
            return cpu_pkg::MEM;
        end
        if (w_we && w_wnum == src) begin
            return cpu_pkg::WB;
        end
        return cpu_pkg::REG;
    endfunction

    function automatic logic hits(
        input logic [4:0] wnum,
        input logic [4:0] src_a,
        input logic [4:0] src_b
    );
        return (wnum != 5'd0) && (wnum == src_a || wnum == src_b);
    endfunction

    assign hz.d_fwd_a = pick_src(hz.d_rs, hz.m_regwrite, hz.m_wnum, hz.w_regwrite, hz.w_wnum);
    assign hz.d_fwd_b = pick_src(hz.d_rt, hz.m_regwrite, hz.m_wnum, hz.w_regwrite, hz.w_wnum);
    assign hz.e_fwd_a = pick_src(hz.e_rs, hz.m_regwrite, hz.m_wnum, hz.w_regwrite, hz.w_wnum);
    assign hz.e_fwd_b = pick_src(hz.e_rt, hz.m_regwrite, hz.m_wnum, hz.w_regwrite, hz.w_wnum);

    assign load_use = hz.e_memread && hits(hz.e_wnum, hz.d_rs, hz.d_rt);

    // branch compares in decode, so anything not yet forwardable must wait
    assign branch_stall = hz.d_is_branch &&
                          ((hz.e_regwrite && hits(hz.e_wnum, hz.d_rs, hz.d_rt)) ||
                           (hz.m_memread && hits(hz.m_wnum, hz.d_rs, hz.d_rt)));

    assign stall = load_use || branch_stall;

    // hold fetch and decode, send a bubble into execute
    assign hz.stall_f = stall;
    assign hz.stall_d = stall;
    assign hz.flush_e = stall;

endmodule

/* decode_stage.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module decode_stage (
    input  cpu_pkg::fd_t         fd,
    input  logic [`CPU_XLEN-1:0] rs_data,
    input  logic [`CPU_XLEN-1:0] rt_data,
    input  logic [`CPU_XLEN-1:0] mem_fwd,
    input  logic [`CPU_XLEN-1:0] wb_fwd,
    input  cpu_pkg::fwd_sel_t    fwd_a,
    input  cpu_pkg::fwd_sel_t    fwd_b,
    input  logic [`CPU_XLEN-1:0] pc_plus4,
    output logic [4:0]           rs,
    output logic [4:0]           rt,
    output logic [4:0]           wnum,
    output cpu_pkg::de_t         de,
    output logic                 is_branch,
    output logic [`CPU_XLEN-1:0] next_pc
);

    // funct codes under OP_SPECIAL
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    cpu_pkg::opcode_t     opcode;
    cpu_pkg::ctrl_t       ctrl;
    logic [5:0]           funct;
    logic [`CPU_XLEN-1:0] a_val;
    logic [`CPU_XLEN-1:0] b_val;
    logic [`CPU_XLEN-1:0] sext_imm;
    logic [`CPU_XLEN-1:0] imm;
    logic [`CPU_XLEN-1:0] delay_pc;
    logic                 use_rd;
    logic                 taken;

    assign opcode    = cpu_pkg::opcode_t'(fd.instr[31:26]);
    assign funct     = fd.instr[5:0];
    assign rs        = fd.instr[25:21];
    assign rt        = fd.instr[20:16];
    assign is_branch = (opcode == cpu_pkg::OP_BEQ) || (opcode == cpu_pkg::OP_BNE);

    assign a_val    = cpu_pkg::fwd_mux(fwd_a, rs_data, mem_fwd, wb_fwd);
    assign b_val    = cpu_pkg::fwd_mux(fwd_b, rt_data, mem_fwd, wb_fwd);
    assign sext_imm = {{(`CPU_XLEN-16){fd.instr[15]}}, fd.instr[15:0]};
    assign delay_pc = fd.pc + 32'd4;

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = cpu_pkg::ADD;
        imm         = sext_imm;
        use_rd      = 1'b0;
        case (opcode)
            cpu_pkg::OP_SPECIAL: begin
                use_rd        = 1'b1;
                ctrl.regwrite = 1'b1;
                case (funct)
                    FN_ADDU: ctrl.alu_op = cpu_pkg::ADD;
                    FN_SUBU: ctrl.alu_op = cpu_pkg::SUB;
                    FN_AND:  ctrl.alu_op = cpu_pkg::AND;
                    FN_OR:   ctrl.alu_op = cpu_pkg::OR;
                    FN_SLT:  ctrl.alu_op = cpu_pkg::SLT;
                    default: ctrl.regwrite = 1'b0;
                endcase
            end
            cpu_pkg::OP_ADDIU: begin
                ctrl.regwrite    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            cpu_pkg::OP_LUI: begin
                ctrl.regwrite    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = cpu_pkg::LUI;
                imm              = {{(`CPU_XLEN-16){1'b0}}, fd.instr[15:0]};
            end
            cpu_pkg::OP_LW: begin
                ctrl.regwrite    = 1'b1;
                ctrl.memread     = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            cpu_pkg::OP_SW: begin
                ctrl.memwrite    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            // branches, j and unknown encodings write nothing
            default: ;
        endcase

        wnum = use_rd ? fd.instr[15:11] : rt;
        // a write to register 0 retires as a no-op
        if (wnum == 5'd0) begin
            ctrl.regwrite = 1'b0;
        end

        taken = ((opcode == cpu_pkg::OP_BEQ) && (a_val == b_val)) ||
                ((opcode == cpu_pkg::OP_BNE) && (a_val != b_val));

        // targets are relative to the delay slot
        if (opcode == cpu_pkg::OP_J) begin
            next_pc = {delay_pc[31:28], fd.instr[25:0], 2'b00};
        end else if (taken) begin
            next_pc = delay_pc + {sext_imm[`CPU_XLEN-3:0], 2'b00};
        end else begin
            next_pc = pc_plus4;
        end

        de.ctrl   = ctrl;
        de.pc     = fd.pc;
        de.rsdata = a_val;
        de.rtdata = b_val;
        de.imm    = imm;
        de.rs     = rs;
        de.rt     = rt;
        de.wnum   = wnum;
    end

endmodule

/* execute_stage.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module execute_stage (
    input  cpu_pkg::de_t         de,
    input  logic [`CPU_XLEN-1:0] mem_fwd,
    input  logic [`CPU_XLEN-1:0] wb_fwd,
    input  cpu_pkg::fwd_sel_t    fwd_a,
    input  cpu_pkg::fwd_sel_t    fwd_b,
    output cpu_pkg::em_t         em
);

    logic [`CPU_XLEN-1:0] src_a;
    logic [`CPU_XLEN-1:0] rt_val;
    logic [`CPU_XLEN-1:0] src_b;
    logic [`CPU_XLEN-1:0] result;

    assign src_a  = cpu_pkg::fwd_mux(fwd_a, de.rsdata, mem_fwd, wb_fwd);
    assign rt_val = cpu_pkg::fwd_mux(fwd_b, de.rtdata, mem_fwd, wb_fwd);
    assign src_b  = de.ctrl.alu_src_imm ? de.imm : rt_val;

    always_comb begin
        case (de.ctrl.alu_op)
            cpu_pkg::ADD: result = src_a + src_b;
            cpu_pkg::SUB: result = src_a - src_b;
            cpu_pkg::AND: result = src_a & src_b;
            cpu_pkg::OR:  result = src_a | src_b;
            cpu_pkg::SLT: result = {{(`CPU_XLEN-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            cpu_pkg::LUI: result = {src_b[15:0], 16'h0000};
            default:      result = '0;
        endcase
    end

    // store data leaves with the forwarded rt value
    assign em.ctrl    = de.ctrl;
    assign em.pc      = de.pc;
    assign em.alu_out = result;
    assign em.rtdata  = rt_val;
    assign em.wnum    = de.wnum;

endmodule

/* datapath.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module datapath (
    input  logic                 clk,
    input  logic                 reset,
    output logic [`CPU_XLEN-1:0] inst_addr,
    input  logic [31:0]          inst_rdata,
    output logic                 data_req,
    output logic                 data_wr,
    output logic [`CPU_XLEN-1:0] data_addr,
    output logic [`CPU_XLEN-1:0] data_wdata,
    input  logic [`CPU_XLEN-1:0] data_rdata,
    output logic [`CPU_XLEN-1:0] debug_wb_pc,
    output logic [3:0]           debug_wb_rf_wen,
    output logic [4:0]           debug_wb_rf_wnum,
    output logic [`CPU_XLEN-1:0] debug_wb_rf_wdata,
    hazard_if.dp                 hz
);

    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] pc_plus4;
    logic [`CPU_XLEN-1:0] next_pc;
    logic [`CPU_XLEN-1:0] rs_data;
    logic [`CPU_XLEN-1:0] rt_data;
    logic [`CPU_XLEN-1:0] wb_data;

    cpu_pkg::fd_t fd_d, fd_q;
    cpu_pkg::de_t de_d, de_q;
    cpu_pkg::em_t em_d, em_q;
    cpu_pkg::mw_t mw_d, mw_q;

    // fetch
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `CPU_RESET_PC;
        end else if (!hz.stall_f) begin
            pc <= next_pc;
        end
    end

    assign pc_plus4  = pc + 32'd4;
    assign inst_addr = pc;
    assign fd_d      = '{instr: inst_rdata, pc: pc};

    pipe_reg #(.payload_t(cpu_pkg::fd_t)) u_fd_reg (
        .clk   (clk),
        .reset (reset),
        .stall (hz.stall_d),
        .clear (1'b0),
        .d     (fd_d),
        .q     (fd_q)
    );

    // decode
    regfile u_regfile (
        .clk     (clk),
        .reset   (reset),
        .wen     (mw_q.regwrite),
        .waddr   (mw_q.wnum),
        .wdata   (wb_data),
        .raddr_a (hz.d_rs),
        .raddr_b (hz.d_rt),
        .rdata_a (rs_data),
        .rdata_b (rt_data)
    );

    decode_stage u_decode (
        .fd        (fd_q),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .mem_fwd   (em_q.alu_out),
        .wb_fwd    (wb_data),
        .fwd_a     (hz.d_fwd_a),
        .fwd_b     (hz.d_fwd_b),
        .pc_plus4  (pc_plus4),
        .rs        (hz.d_rs),
        .rt        (hz.d_rt),
        .wnum      (),
        .de        (de_d),
        .is_branch (hz.d_is_branch),
        .next_pc   (next_pc)
    );

    pipe_reg #(.payload_t(cpu_pkg::de_t)) u_de_reg (
        .clk   (clk),
        .reset (reset),
        .stall (1'b0),
        .clear (hz.flush_e),
        .d     (de_d),
        .q     (de_q)
    );

    // execute
    execute_stage u_execute (
        .de      (de_q),
        .mem_fwd (em_q.alu_out),
        .wb_fwd  (wb_data),
        .fwd_a   (hz.e_fwd_a),
        .fwd_b   (hz.e_fwd_b),
        .em      (em_d)
    );

    assign hz.e_rs       = de_q.rs;
    assign hz.e_rt       = de_q.rt;
    assign hz.e_wnum     = de_q.wnum;
    assign hz.e_regwrite = de_q.ctrl.regwrite;
    assign hz.e_memread  = de_q.ctrl.memread;

    pipe_reg #(.payload_t(cpu_pkg::em_t)) u_em_reg (
        .clk   (clk),
        .reset (reset),
        .stall (1'b0),
        .clear (1'b0),
        .d     (em_d),
        .q     (em_q)
    );

    // memory, read data comes back in the same cycle
    assign data_req   = em_q.ctrl.memread | em_q.ctrl.memwrite;
    assign data_wr    = em_q.ctrl.memwrite;
    assign data_addr  = em_q.alu_out;
    assign data_wdata = em_q.rtdata;

    assign hz.m_wnum     = em_q.wnum;
    assign hz.m_regwrite = em_q.ctrl.regwrite;
    assign hz.m_memread  = em_q.ctrl.memread;

    assign mw_d = '{regwrite: em_q.ctrl.regwrite, memread: em_q.ctrl.memread, pc: em_q.pc,
                    alu_out: em_q.alu_out, rdata: data_rdata, wnum: em_q.wnum};

    pipe_reg #(.payload_t(cpu_pkg::mw_t)) u_mw_reg (
        .clk   (clk),
        .reset (reset),
        .stall (1'b0),
        .clear (1'b0),
        .d     (mw_d),
        .q     (mw_q)
    );

    // writeback
    assign wb_data       = mw_q.memread ? mw_q.rdata : mw_q.alu_out;
    assign hz.w_wnum     = mw_q.wnum;
    assign hz.w_regwrite = mw_q.regwrite;

    assign debug_wb_pc       = mw_q.pc;
    assign debug_wb_rf_wen   = {4{mw_q.regwrite}};
    assign debug_wb_rf_wnum  = mw_q.wnum;
    assign debug_wb_rf_wdata = wb_data;

endmodule

/* cpu_top.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_top (
    input  logic                 clk,
    input  logic                 reset,
    output logic                 inst_req,
    output logic [`CPU_XLEN-1:0] inst_addr,
    input  logic [31:0]          inst_rdata,
    output logic                 data_req,
    output logic                 data_wr,
    output logic [`CPU_XLEN-1:0] data_addr,
    output logic [`CPU_XLEN-1:0] data_wdata,
    input  logic [`CPU_XLEN-1:0] data_rdata,
    output logic [`CPU_XLEN-1:0] debug_wb_pc,
    output logic [3:0]           debug_wb_rf_wen,
    output logic [4:0]           debug_wb_rf_wnum,
    output logic [`CPU_XLEN-1:0] debug_wb_rf_wdata
);

    hazard_if hz_if ();

    // fetch every cycle out of reset
    assign inst_req = ~reset;

    datapath u_datapath (
        .clk               (clk),
        .reset             (reset),
        .inst_addr         (inst_addr),
        .inst_rdata        (inst_rdata),
        .data_req          (data_req),
        .data_wr           (data_wr),
        .data_addr         (data_addr),
        .data_wdata        (data_wdata),
        .data_rdata        (data_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .hz                (hz_if.dp)
    );

    hazard_unit u_hazard (
        .hz (hz_if.hz)
    );

endmodule

/* cpu_props.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_props (
    input logic                 clk,
    input logic                 reset,
    input logic                 data_req,
    input logic [`CPU_XLEN-1:0] inst_addr,
    input logic [3:0]           debug_wb_rf_wen,
    input logic [4:0]           debug_wb_rf_wnum
);

    // register 0 is hardwired and never retires a write
    wb_not_zero: assert property (@(posedge clk) disable iff (reset)
        (debug_wb_rf_wen != 4'b0000) |-> (debug_wb_rf_wnum != 5'd0))
        else $error("register 0 reported as written");

    // memory port idle once reset has cleared the stage registers
    idle_in_reset: assert property (@(posedge clk)
        ($past(reset) && reset) |-> !data_req)
        else $error("data_req high during reset");

    fetch_aligned: assert property (@(posedge clk) disable iff (reset)
        inst_addr[1:0] == 2'b00)
        else $error("inst_addr not word aligned");

endmodule

bind datapath cpu_props u_props (
    .clk              (clk),
    .reset            (reset),
    .data_req         (data_req),
    .inst_addr        (inst_addr),
    .debug_wb_rf_wen  (debug_wb_rf_wen),
    .debug_wb_rf_wnum (debug_wb_rf_wnum)
);

/* cpu_tb.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_tb;

    localparam logic [5:0] OPC_ADDIU = 6'h09;
    localparam logic [5:0] OPC_LUI   = 6'h0f;
    localparam logic [5:0] OPC_LW    = 6'h23;
    localparam logic [5:0] OPC_SW    = 6'h2b;
    localparam logic [5:0] OPC_BEQ   = 6'h04;
    localparam logic [5:0] OPC_BNE   = 6'h05;
    localparam logic [5:0] FN_ADDU   = 6'h21;
    localparam logic [5:0] FN_SUBU   = 6'h23;
    localparam logic [5:0] FN_AND    = 6'h24;
    localparam logic [5:0] FN_OR     = 6'h25;
    localparam logic [5:0] FN_SLT    = 6'h2a;

    logic        clk;
    logic        reset;
    logic        inst_req;
    logic [31:0] inst_addr;
    logic [31:0] inst_rdata;
    logic        data_req;
    logic        data_wr;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic [31:0] data_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] imem [0:63];
    logic [31:0] dmem [0:63];
    logic [31:0] prog [$];
    string       row_name [$];
    logic [31:0] row_pc [$];
    logic [4:0]  row_num [$];
    logic [31:0] row_val [$];
    int          mem_cycles = 0;
    int          store_cycles = 0;

    cpu_top UUT (
        .clk               (clk),
        .reset             (reset),
        .inst_req          (inst_req),
        .inst_addr         (inst_addr),
        .inst_rdata        (inst_rdata),
        .data_req          (data_req),
        .data_wr           (data_wr),
        .data_addr         (data_addr),
        .data_wdata        (data_wdata),
        .data_rdata        (data_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    // both memories answer in the same cycle
    assign inst_rdata = imem[inst_addr[7:2]];
    assign data_rdata = dmem[data_addr[7:2]];

    always @(posedge clk) begin
        if (data_req && data_wr) begin
            dmem[data_addr[7:2]] <= data_wdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [5:0] fn);
        return {6'h00, rs, rt, rd, 5'h00, fn};
    endfunction

    function automatic logic [31:0] j_type(input logic [31:0] target);
        return {6'h02, target[27:2]};
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped");
    endtask

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("mismatch: %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // advance one cycle and sample the fetch strobe and memory port
    task automatic next_cycle();
        @(negedge clk);
        compare("fetch strobe", 32'd1, {31'd0, inst_req});
        if (data_req) begin
            mem_cycles++;
        end
        if (data_req && data_wr) begin
            store_cycles++;
        end
    endtask

    task automatic expect_write(input string name, input logic [31:0] pc,
                                input logic [4:0] num, input logic [31:0] val);
        row_name.push_back(name);
        row_pc.push_back(pc);
        row_num.push_back(num);
        row_val.push_back(val);
    endtask

    task automatic load_program();
        prog.push_back(i_type(OPC_ADDIU, 0, 1, 16'd5));        // 0x00
        prog.push_back(i_type(OPC_ADDIU, 1, 2, 16'hfffd));     // 0x04
        prog.push_back(r_type(1, 2, 3, FN_ADDU));               // 0x08
        prog.push_back(r_type(3, 1, 4, FN_SUBU));
        prog.push_back(r_type(3, 4, 5, FN_AND));                // 0x10
        prog.push_back(r_type(5, 3, 6, FN_OR));
        prog.push_back(r_type(2, 6, 7, FN_SLT));
        prog.push_back(i_type(OPC_LUI, 0, 8, 16'hffff));
        prog.push_back(r_type(8, 7, 9, FN_SLT));                // 0x20
        prog.push_back(i_type(OPC_ADDIU, 0, 10, 16'h0040));
        prog.push_back(i_type(OPC_SW, 10, 3, 16'd0));
        prog.push_back(i_type(OPC_LW, 10, 11, 16'd0));
        prog.push_back(r_type(11, 1, 12, FN_ADDU));             // 0x30
        prog.push_back(i_type(OPC_LW, 0, 13, 16'd8));
        prog.push_back(i_type(OPC_LW, 0, 14, 16'd12));
        prog.push_back(r_type(13, 14, 15, FN_ADDU));
        prog.push_back(i_type(OPC_ADDIU, 0, 16, 16'd3));        // 0x40
        prog.push_back(i_type(OPC_ADDIU, 0, 17, 16'd3));
        prog.push_back(i_type(OPC_BEQ, 16, 17, 16'd2));
        prog.push_back(i_type(OPC_ADDIU, 0, 18, 16'd1));
        prog.push_back(i_type(OPC_ADDIU, 0, 18, 16'd99));       // 0x50, skipped
        prog.push_back(i_type(OPC_ADDIU, 16, 19, 16'd0));
        prog.push_back(i_type(OPC_BNE, 19, 16, 16'd5));
        prog.push_back(i_type(OPC_ADDIU, 0, 20, 16'd2));
        prog.push_back(j_type(32'h0000_0070));                  // 0x60
        prog.push_back(i_type(OPC_ADDIU, 0, 21, 16'h0021));
        prog.push_back(i_type(OPC_ADDIU, 0, 22, 16'h0055));     // skipped
        prog.push_back(i_type(OPC_ADDIU, 0, 23, 16'h0066));     // skipped
        prog.push_back(i_type(OPC_ADDIU, 0, 0, 16'd9));         // 0x70
        prog.push_back(r_type(21, 20, 24, FN_ADDU));
        prog.push_back(r_type(24, 0, 25, FN_OR));
        for (int i = 0; i < 64; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : 32'h0000_0000;
        end
    endtask

    task automatic build_expectations();
        expect_write("addiu", 32'h00, 1, 32'd5);
        expect_write("addiu mem forward", 32'h04, 2, 32'd2);
        expect_write("addu", 32'h08, 3, 32'd7);
        expect_write("subu", 32'h0c, 4, 32'd2);
        expect_write("and", 32'h10, 5, 32'd2);
        expect_write("or", 32'h14, 6, 32'd7);
        expect_write("slt", 32'h18, 7, 32'd1);
        expect_write("lui", 32'h1c, 8, 32'hffff_0000);
        expect_write("slt signed", 32'h20, 9, 32'd1);
        expect_write("store base", 32'h24, 10, 32'h40);
        expect_write("load after store", 32'h2c, 11, 32'd7);
        expect_write("load use", 32'h30, 12, 32'd12);
        expect_write("load seeded word 2", 32'h34, 13, dmem[2]);
        expect_write("load seeded word 3", 32'h38, 14, dmem[3]);
        expect_write("load use sum", 32'h3c, 15, dmem[2] + dmem[3]);
        expect_write("beq source a", 32'h40, 16, 32'd3);
        expect_write("beq source b", 32'h44, 17, 32'd3);
        expect_write("beq delay slot", 32'h4c, 18, 32'd1);
        expect_write("beq target", 32'h54, 19, 32'd3);
        expect_write("bne delay slot", 32'h5c, 20, 32'd2);
        expect_write("j delay slot", 32'h64, 21, 32'h21);
        expect_write("j target", 32'h74, 24, 32'h23);
        expect_write("tail or", 32'h78, 25, 32'h23);
    endtask

    initial begin
        reset = 1'b1;
        void'($urandom(32'h879e773e));
        for (int i = 0; i < 64; i++) begin
            dmem[i] = $urandom();
        end
        load_program();
        build_expectations();

        repeat (5) @(negedge clk);
        reset = 1'b0;
        compare("reset pc", `CPU_RESET_PC, inst_addr);

        for (int i = 0; i < row_pc.size(); i++) begin
            next_cycle();
            while (debug_wb_rf_wen == 4'b0000) begin
                next_cycle();
            end
            compare({row_name[i], " pc"}, row_pc[i], debug_wb_pc);
            compare({row_name[i], " wen"}, 32'hf, {28'd0, debug_wb_rf_wen});
            compare({row_name[i], " wnum"}, {27'd0, row_num[i]}, {27'd0, debug_wb_rf_wnum});
            compare({row_name[i], " value"}, row_val[i], debug_wb_rf_wdata);
        end

        // only no-ops follow, so nothing else may retire
        repeat (10) begin
            next_cycle();
            if (debug_wb_rf_wen != 4'b0000) begin
                fail_run($sformatf("unexpected register write at pc %h", debug_wb_pc));
            end
        end

        // one sw and three lw reach the memory stage
        compare("data accesses", 32'd4, mem_cycles);
        compare("store accesses", 32'd1, store_cycles);

        $display("PASS: all tests");
        $finish;
    end

    initial begin
        #1;
        #((prog.size() + 20) * 160);
        fail_run("watchdog: the program did not finish in time");
    end

endmodule

/* cpu_top.f */
+incdir+.
cpu_pkg.sv
hazard_if.sv
pipe_reg.sv
regfile.sv
hazard_unit.sv
decode_stage.sv
execute_stage.sv
datapath.sv
cpu_top.sv
cpu_props.sv
cpu_tb.sv

/* run.sh */
#!/bin/sh
# build and run the cpu testbench with Verilator, then scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f cpu_top.f --top-module cpu_tb -o cpu_sim \
    || { echo "build failed"; exit 1; }
./obj_dir/cpu_sim > sim.log 2>&1
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "simulation did not finish"; exit 1; }
echo "simulation passed"
